/* dv/rvMiniTb.sv */
//******************************
// mini RV32I core testbench with an AXI memory and random stalls,
// random program, ISA reference model, assertions and watchdog
//******************************
`timescale 1ns/1ns

module rvMiniTb import rvMiniPkg::*; ();

   localparam int          ClkPeriod       = 100;       // ns
   localparam int          ResetCycles     = 16;
   localparam int          ProgWords       = 200;
   localparam int          NumRetire       = 300;
   localparam int          CyclesPerRetire = 40;        // shifts and stalls included
   localparam logic [31:0] Seed            = 32'd74804;

   logic        clk;
   logic        rst;
   logic        arready;
   logic        rready;
   axiAr_t      axiAr;
   axiR_t       axiR;
   retire_t     retire;

   logic [31:0] prog [ProgWords];   // program image by word address
   logic [31:0] rngState;
   logic [31:0] stallDraw;
   logic [1:0]  arWait;             // cycles before arready
   logic [1:0]  rWait;              // cycles before rvalid
   logic        rPending;
   logic [31:0] rAddr;
   int          readsOpen;          // AR accepted and R not yet back
   logic        resetClocked;
   int          retired;

   // reference model state and the record it expects next
   logic [31:0] xReg [32];
   logic [31:0] mPc;
   logic [31:0] expPc;
   logic [31:0] expValue;
   logic [31:0] expMemAddr;
   logic [4:0]  expRd;
   logic        expWrEn;
   logic        expIsMem;

   rvMiniCore #(.QueueDepth(4), .ResetPc(32'h0)) dut (
      .clk(clk), .rst(rst),
      .axiAr(axiAr), .arready(arready), .axiR(axiR), .rready(rready),
      .retire(retire)
   );

   function automatic logic [31:0] drawRandom();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
         input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] sTypeWord(input logic [11:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // sw
   endfunction

   function automatic logic [31:0] bTypeWord(input logic [12:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jTypeWord(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // addi x0 past the program with an immediate folded from the address
   function automatic logic [31:0] memWord(input logic [31:0] addr);
      if (addr < 32'(ProgWords * 4)) return prog[addr[9:2]];
      return {addr[31:20] ^ addr[19:8] ^ {addr[7:0], 4'h0}, 20'h00013};
   endfunction

   function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic [31:0] a,
         input logic [31:0] b, input logic alt);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return {31'd0, $signed(a) < $signed(b)};
         3'b011:  return {31'd0, a < b};
         3'b100:  return a ^ b;
         3'b101: begin
            if (alt) return $signed(a) >>> b[4:0];               // sign fill
            return a >> b[4:0];
         end
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
         input logic [31:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic buildProgram();
      logic [31:0] r;
      logic [31:0] r2;
      logic [31:0] off;
      logic [4:0]  rd, rs1, rs2;
      logic [2:0]  aluF3, shF3, brF3;
      logic [6:0]  shF7, regF7;
      int          i;
      int          t;
      for (i = 0; i < ProgWords; i++) begin
         r     = drawRandom();
         r2    = drawRandom();
         rd    = {2'b00, r[6:4]};                      // only x0..x7 in use
         rs1   = {2'b00, r[9:7]};
         rs2   = {2'b00, r[12:10]};
         aluF3 = r[15:13];
         if (aluF3 == 3'b001) aluF3 = 3'b000;          // no shifts here
         if (aluF3 == 3'b101) aluF3 = 3'b111;
         regF7 = (aluF3 == 3'b000 && r[16]) ? 7'h20 : 7'h00;   // sub
         shF3  = r[13] ? 3'b101 : 3'b001;
         shF7  = (shF3 == 3'b101 && r[16]) ? 7'h20 : 7'h00;    // sra, srai
         brF3  = r[15:13];
         if (brF3 == 3'b010) brF3 = 3'b000;
         if (brF3 == 3'b011) brF3 = 3'b001;
         t = i + 1 + int'(r[19:17]) % 6;                // forward target word
         if (t > ProgWords - 1) t = ProgWords - 1;
         off = 32'((t - i) * 4);
         if (i < 7) begin
            prog[i] = {r2[31:12], 5'(i + 1), 7'b0110111};                   // lui x1..x7
         end else if (i < 14) begin
            prog[i] = iTypeWord(r2[11:0], 5'(i - 6), 3'b000, 5'(i - 6), 7'b0010011);
         end else if (i == ProgWords - 1) begin
            off = 32'(-4 * i);
            prog[i] = jTypeWord(off[20:0], 5'd0);      // loop back with link into x0
         end else begin
            case (r[3:0])
               4'd0:        prog[i] = {r2[31:12], rd, 7'b0110111};          // lui
               4'd1:        prog[i] = {r2[31:12], rd, 7'b0010111};          // auipc
               4'd2, 4'd3:  prog[i] = iTypeWord(r2[11:0], rs1, aluF3, rd, 7'b0010011);
               4'd4, 4'd5:  prog[i] = rTypeWord(regF7, rs2, rs1, aluF3, rd);
               4'd6, 4'd7:  prog[i] = iTypeWord({shF7, r2[4:0]}, rs1, shF3, rd, 7'b0010011);
               4'd8, 4'd15: prog[i] = rTypeWord(shF7, rs2, rs1, shF3, rd);  // amount from rs2
               4'd9, 4'd10: prog[i] = bTypeWord(off[12:0], rs2, rs1, brF3);
               4'd11:       prog[i] = jTypeWord(off[20:0], rd);
               // absolute target off x0 and odd now and then
               4'd12: prog[i] = iTypeWord(12'(4 * t) | {11'd0, r2[0]}, 5'd0, 3'b000, rd,
                                          7'b1100111);
               4'd13:       prog[i] = iTypeWord(r2[11:0], rs1, 3'b010, rd, 7'b0000011);
               default:     prog[i] = sTypeWord(r2[11:0], rs2, rs1);
            endcase
         end
      end
   endtask

   // executes the next instruction on the model path
   task automatic stepModel();
      logic [31:0] ins, a, b, nextPc;
      logic [31:0] immI, immS, immB, immU, immJ;
      ins      = memWord(mPc);
      a        = xReg[ins[19:15]];
      b        = xReg[ins[24:20]];
      immI     = {{20{ins[31]}}, ins[31:20]};
      immS     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB     = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      immU     = {ins[31:12], 12'd0};
      immJ     = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      nextPc   = mPc + 32'd4;
      expPc    = mPc;
      expRd    = ins[11:7];
      expWrEn  = 1'b0;
      expValue = 32'd0;
      expIsMem = 1'b0;
      case (ins[6:0])
         7'b0110111: begin
            expWrEn  = 1'b1;
            expValue = immU;
         end
         7'b0010111: begin
            expWrEn  = 1'b1;
            expValue = mPc + immU;
         end
         7'b1101111: begin
            expWrEn  = 1'b1;
            expValue = mPc + 32'd4;
            nextPc   = mPc + immJ;
         end
         7'b1100111: begin
            expWrEn  = 1'b1;
            expValue = mPc + 32'd4;
            nextPc   = (a + immI) & ~32'd1;
         end
         7'b1100011: if (branchTaken(ins[14:12], a, b)) nextPc = mPc + immB;
         7'b0010011: begin
            expWrEn  = 1'b1;
            expValue = aluResult(ins[14:12], a, immI, ins[14:12] == 3'b101 && ins[30]);
         end
         7'b0110011: begin
            expWrEn  = 1'b1;
            expValue = aluResult(ins[14:12], a, b, ins[30]);
         end
         7'b0000011: begin
            expIsMem   = 1'b1;                          // no register write
            expMemAddr = a + immI;
         end
         7'b0100011: begin
            expIsMem   = 1'b1;
            expMemAddr = a + immS;
         end
         default: ;
      endcase
      if (expWrEn && expRd != 5'd0) xReg[expRd] = expValue;   // x0 stays zero
      mPc = nextPc;
   endtask

   task automatic failRun(input string what);
      $display("Checks failed");
      $display("%s", what);
      $fatal(1);
   endtask

   task automatic reportMismatch(input string name, input logic [31:0] expected,
         input logic [31:0] actual);
      failRun($sformatf("Mismatch at %0t ns: %s expected %h got %h", $time, name,
                        expected, actual));
   endtask

   initial begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   // AXI read slave with random stalls on both channels
   always @(posedge clk) begin
      if (rst) begin
         arready  <= 1'b0;
         axiR     <= '0;
         rPending <= 1'b0;
         arWait   <= 2'd0;
         rWait    <= 2'd0;
      end else begin
         if (axiAr.arvalid && arready) begin
            stallDraw = drawRandom();
            arready  <= 1'b0;
            rAddr    <= axiAr.araddr;
            rPending <= 1'b1;
            rWait    <= stallDraw[1:0];
            arWait   <= stallDraw[9:8];                 // for the next address
         end else if (axiAr.arvalid) begin
            if (arWait == 2'd0) arready <= 1'b1;
            else arWait <= arWait - 2'd1;
         end
         if (axiR.rvalid && rready) begin
            axiR.rvalid <= 1'b0;
         end else if (rPending) begin
            if (rWait == 2'd0) begin
               axiR     <= {1'b1, memWord(rAddr), 2'b00};   // okay response
               rPending <= 1'b0;
            end else begin
               rWait <= rWait - 2'd1;
            end
         end
      end
   end

   always @(posedge clk) begin
      if (rst) readsOpen <= 0;
      else readsOpen <= readsOpen + int'(axiAr.arvalid && arready)
                                  - int'(axiR.rvalid && rready);
      resetClocked <= 1'b1;                              // first edge has passed
   end

   // the record is stepped on the falling edge since retire is registered
   always @(negedge clk) begin
      if (!rst && retire.valid) begin
         stepModel();
         retired = retired + 1;
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      axiAr.arvalid && !arready |=> axiAr.arvalid && $stable(axiAr.araddr))
      else failRun("arvalid dropped or araddr changed while arready was low");
   assert property (@(posedge clk) disable iff (rst)
      axiAr.arvalid |-> axiAr.araddr[1:0] == 2'b00)
      else failRun("araddr is not word aligned");
   assert property (@(posedge clk) disable iff (rst)
      axiAr.arvalid && arready |-> readsOpen == 0)
      else failRun("a second read was issued while one was outstanding");
   assert property (@(posedge clk)
      rst && resetClocked |-> !axiAr.arvalid && !retire.valid)
      else failRun("arvalid or retire valid high during reset");
   // fetch reads are instruction accesses
   assert property (@(posedge clk) disable iff (rst) axiAr.arvalid |-> axiAr.arprot[2])
      else reportMismatch("axiAr.arprot[2]", 32'd1, $sampled(axiAr.arprot[2]));
   assert property (@(posedge clk) disable iff (rst) rready)
      else reportMismatch("rready", 32'd1, $sampled(rready));

   assert property (@(posedge clk) disable iff (rst) retire.valid |-> retire.pc == expPc)
      else reportMismatch("retire.pc", $sampled(expPc), $sampled(retire.pc));
   assert property (@(posedge clk) disable iff (rst) retire.valid |-> retire.wrEn == expWrEn)
      else reportMismatch("retire.wrEn", $sampled(expWrEn), $sampled(retire.wrEn));
   assert property (@(posedge clk) disable iff (rst)
      retire.valid && expWrEn |-> retire.rd == expRd)
      else reportMismatch("retire.rd", $sampled(expRd), $sampled(retire.rd));
   assert property (@(posedge clk) disable iff (rst)
      retire.valid && expWrEn |-> retire.value == expValue)
      else reportMismatch("retire.value", $sampled(expValue), $sampled(retire.value));
   assert property (@(posedge clk) disable iff (rst)
      retire.valid |-> retire.isMem == expIsMem)
      else reportMismatch("retire.isMem", $sampled(expIsMem), $sampled(retire.isMem));
   assert property (@(posedge clk) disable iff (rst)
      retire.valid && expIsMem |-> retire.memAddr == expMemAddr)
      else reportMismatch("retire.memAddr", $sampled(expMemAddr), $sampled(retire.memAddr));

   initial begin
      rst          <= 1'b1;
      arready      <= 1'b0;
      axiR         <= '0;
      rngState     = Seed;
      mPc          = 32'h0;
      retired      = 0;
      resetClocked <= 1'b0;
      expWrEn      = 1'b0;
      expIsMem     = 1'b0;
      for (int k = 0; k < 32; k++) xReg[k] = 32'd0;
      buildProgram();
      repeat (ResetCycles) @(posedge clk);
      rst <= 1'b0;
      wait (retired >= NumRetire);
      @(negedge clk);                                    // last record checked on the edge between
      $display("All checks passed");
      $finish;
   end

   initial begin
      #((ResetCycles + NumRetire * CyclesPerRetire) * ClkPeriod);
      failRun($sformatf("timeout with %0d of %0d instructions retired", retired, NumRetire));
   end

endmodule

/* rtl/execUnit.sv */
//******************************
// execute unit: register file, ALU with serial shifter,
// branch resolution, redirect and retire record
//******************************
`timescale 1ns/1ns

module execUnit import rvMiniPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        headValid,
   input  queueEntry_t head,
   output logic        pop,
   output redirect_t   redirect,
   output retire_t     retire
);

   decode_t     dec;
   logic [31:0] regs [32];
   logic [31:0] rs1Val, rs2Val;
   logic [31:0] aluIn1, aluIn2;
   logic [31:0] aluPlus, aluOut, shiftOut, shVal;
   logic [31:0] pcPlus4, wbData;
   logic [32:0] aluMinus, cmpMinus;
   logic [2:0]  op;
   logic [4:0]  shAmt, shCnt;
   logic        aluLt, cmpLt, predicate, taken, wrEn;
   logic        shBusy, shiftDone;

   function automatic logic [31:0] shiftOne(input logic [31:0] v, input logic left,
                                            input logic arith);
      logic [31:0] r;
      if (left) r = {v[30:0], 1'b0};
      else      r = {arith & v[31], v[31:1]};
      return r;
   endfunction

   nrvDecoder decoder (.instr(head.instr), .dec(dec));

   assign rs1Val = (dec.inRegId1 == 5'd0) ? 32'd0 : regs[dec.inRegId1];   // x0 reads zero
   assign rs2Val = (dec.inRegId2 == 5'd0) ? 32'd0 : regs[dec.inRegId2];
   assign aluIn1 = dec.aluInSel1 ? head.pc : rs1Val;
   assign aluIn2 = dec.aluInSel2 ? dec.imm : rs2Val;
   assign op     = dec.aluSel ? dec.aluOp : 3'b000;                       // forced add
   assign shAmt  = aluIn2[4:0];

   assign aluPlus  = aluIn1 + aluIn2;
   assign aluMinus = {1'b0, aluIn1} - {1'b0, aluIn2};
   assign aluLt    = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : aluMinus[32];
   assign cmpMinus = {1'b0, rs1Val} - {1'b0, rs2Val};                     // branch compare
   assign cmpLt    = (rs1Val[31] ^ rs2Val[31]) ? rs1Val[31] : cmpMinus[32];
   assign shiftOut = shBusy ? shVal : aluIn1;                             // amount 0 passes

   always_comb begin
      case (op)
         3'b000:  aluOut = dec.aluQual ? aluMinus[31:0] : aluPlus;
         3'b010:  aluOut = {31'd0, aluLt};
         3'b011:  aluOut = {31'd0, aluMinus[32]};
         3'b100:  aluOut = aluIn1 ^ aluIn2;
         3'b110:  aluOut = aluIn1 | aluIn2;
         3'b111:  aluOut = aluIn1 & aluIn2;
         default: aluOut = shiftOut;                                     // sll, srl, sra
      endcase
   end

   always_comb begin
      case (dec.aluOp)
         3'b000:  predicate = (cmpMinus[31:0] == 32'd0);                 // beq
         3'b001:  predicate = (cmpMinus[31:0] != 32'd0);                 // bne
         3'b100:  predicate = cmpLt;
         3'b101:  predicate = ~cmpLt;
         3'b110:  predicate = cmpMinus[32];                              // bltu
         3'b111:  predicate = ~cmpMinus[32];
         default: predicate = 1'b0;
      endcase
   end

   // shift done when the remaining count runs out
   assign shiftDone = ~dec.needWaitAlu | (shBusy ? (shCnt == 5'd0) : (shAmt == 5'd0));
   assign pop       = headValid & shiftDone;
   assign taken     = (dec.nextPcSel == NpAlu) | ((dec.nextPcSel == NpPredicate) & predicate);
   assign redirect.valid  = pop & taken;
   assign redirect.target = {aluPlus[31:1], 1'b0};                       // jalr clears bit 0

   assign pcPlus4 = head.pc + 32'd4;
   assign wbData  = (dec.wbSel == WbPcPlus4) ? pcPlus4 : aluOut;
   assign wrEn    = dec.wbEn & ((dec.wbSel == WbAlu) | (dec.wbSel == WbPcPlus4));  // no load data

   always_ff @(posedge clk) begin
      if (rst) begin
         shBusy <= 1'b0;
         shCnt  <= 5'd0;
      end else if (headValid && dec.needWaitAlu) begin
         if (!shBusy) begin
            if (shAmt != 5'd0) begin
               shBusy <= 1'b1;
               shVal  <= shiftOne(aluIn1, op == 3'b001, dec.aluQual);    // first bit now
               shCnt  <= shAmt - 5'd1;
            end
         end else if (shCnt == 5'd0) begin
            shBusy <= 1'b0;                                              // result popped
         end else begin
            shVal <= shiftOne(shVal, op == 3'b001, dec.aluQual);
            shCnt <= shCnt - 5'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop && wrEn) regs[dec.wbRegId] <= wbData;
   end

   always_ff @(posedge clk) begin
      retire.pc      <= head.pc;
      retire.rd      <= dec.wbRegId;
      retire.wrEn    <= wrEn;
      retire.value   <= wbData;
      retire.memAddr <= aluPlus;                                         // rs1 + imm
      retire.isMem   <= dec.isLoad | dec.isStore;
      if (rst) retire.valid <= 1'b0;
      else     retire.valid <= pop;
   end

endmodule

/* rtl/fetchUnit.sv */
//******************************
// fetch unit: AXI4-Lite read master,
// sequential fetch with redirect and stale discard
//******************************
`timescale 1ns/1ns

module fetchUnit import rvMiniPkg::*; #(
   parameter logic [31:0] ResetPc = ResetPcDef
) (
   input  logic        clk,
   input  logic        rst,
   output axiAr_t      axiAr,
   input  logic        arready,
   input  axiR_t       axiR,
   output logic        rready,
   input  logic        notFull,     // queue has room
   input  redirect_t   redirect,
   output logic        pushValid,
   output queueEntry_t pushEntry
);

   logic [31:0] pc;          // next address to request
   logic [31:0] araddrQ;     // address of the pending or in-flight read
   logic        arvalidQ;
   logic        inFlight;    // address accepted, data not yet back
   logic        stale;       // pending response belongs to the old path
   logic        issue;
   logic        arHs;
   logic        respDone;

   assign rready   = 1'b1;                                  // responses always have room
   assign arHs     = arvalidQ & arready;
   assign respDone = axiR.rvalid & rready;
   // one read at a time, never on a redirect cycle
   assign issue    = ~arvalidQ & ~inFlight & notFull & ~redirect.valid;

   assign axiAr.arvalid = arvalidQ;
   assign axiAr.araddr  = araddrQ;
   assign axiAr.arprot  = 3'b100;                           // instruction access

   assign pushValid       = respDone & ~stale;              // push on the R handshake
   assign pushEntry.pc    = araddrQ;
   assign pushEntry.instr = axiR.rdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= ResetPc;
         arvalidQ <= 1'b0;
         inFlight <= 1'b0;
         stale    <= 1'b0;
      end else begin
         if (issue) begin
            arvalidQ <= 1'b1;
            pc       <= pc + 32'd4;
         end else if (arHs) begin
            arvalidQ <= 1'b0;                               // address taken, wait for data
            inFlight <= 1'b1;
         end
         if (respDone) inFlight <= 1'b0;
         if (redirect.valid) begin
            pc    <= {redirect.target[31:2], 2'b00};        // keep fetch word aligned
            // a response still to come is from the wrong path
            stale <= (arvalidQ | inFlight) & ~respDone;
         end else if (respDone) begin
            stale <= 1'b0;
         end
      end
   end

   // address is frozen while arvalid is high
   always_ff @(posedge clk) begin
      if (issue) araddrQ <= {pc[31:2], 2'b00};
   end

endmodule

/* rtl/instrQueue.sv */
//******************************
// instruction queue: circular FIFO of words and PCs, with flush
//******************************
`timescale 1ns/1ns

module instrQueue import rvMiniPkg::*; #(
   parameter int QueueDepth = QueueDepthDef
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        pushValid,
   input  queueEntry_t pushEntry,
   output logic        notFull,
   output logic        headValid,
   output queueEntry_t head,
   input  logic        pop,
   input  logic        flush      // drop everything, wins over push
);

   localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
   localparam int CntW = $clog2(QueueDepth + 1);

   queueEntry_t     mem [QueueDepth];
   logic [PtrW-1:0] rdPtr;
   logic [PtrW-1:0] wrPtr;
   logic [CntW-1:0] count;
   logic            doPush;
   logic            doPop;

   assign notFull   = (count != CntW'(QueueDepth));
   assign headValid = (count != '0);
   assign head      = mem[rdPtr];                    // visible the cycle after the push
   assign doPush    = pushValid & notFull;
   assign doPop     = pop & headValid;

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         rdPtr <= '0;
         wrPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) wrPtr <= (wrPtr == PtrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop)  rdPtr <= (rdPtr == PtrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
         case ({doPush, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // none, or push and pop together
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (doPush) mem[wrPtr] <= pushEntry;   // storage, no reset
   end

endmodule

/* rtl/nrvDecoder.sv */
//******************************
// lean RV32I decoder, no illegal instruction check
//******************************
`timescale 1ns/1ns

module nrvDecoder import rvMiniPkg::*; (
   input  instrWord_u instr,
   output decode_t    dec
);

   logic [31:0] iImm;
   logic [31:0] sImm;
   logic [31:0] bImm;
   logic [31:0] uImm;
   logic [31:0] jImm;
   logic        aluOpIsShift;

   // immediates taken through the format views
   assign iImm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
   assign sImm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
   assign bImm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                  instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
   assign uImm = {instr.uType.imm, 12'b0};
   assign jImm = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
                  instr.jType.imm11, instr.jType.imm10to1, 1'b0};

   // sll, srl and sra need the serial shifter
   assign aluOpIsShift = (instr.rType.funct3 == 3'b001) || (instr.rType.funct3 == 3'b101);

   always_comb begin
      dec           = '0;
      dec.wbSel     = WbAlu;
      dec.nextPcSel = NpPlus4;                      // default pc <- pc+4
      dec.wbRegId   = instr.rType.rd;
      dec.inRegId1  = instr.rType.rs1;
      dec.inRegId2  = instr.rType.rs2;
      dec.aluOp     = instr.rType.funct3;
      case (instr.rType.opcode[6:2])
         OpLui: begin
            dec.wbEn      = 1'b1;
            dec.inRegId1  = 5'd0;                   // x0 + imm through the adder
            dec.aluInSel2 = 1'b1;
            dec.imm       = uImm;
         end
         OpAuipc: begin
            dec.wbEn      = 1'b1;
            dec.aluInSel1 = 1'b1;                   // pc + imm
            dec.aluInSel2 = 1'b1;
            dec.imm       = uImm;
         end
         OpJal: begin
            dec.wbEn      = 1'b1;
            dec.wbSel     = WbPcPlus4;              // link
            dec.aluInSel1 = 1'b1;
            dec.aluInSel2 = 1'b1;
            dec.nextPcSel = NpAlu;
            dec.imm       = jImm;
         end
         OpJalr: begin
            dec.wbEn      = 1'b1;
            dec.wbSel     = WbPcPlus4;
            dec.aluInSel2 = 1'b1;                   // rs1 + imm
            dec.nextPcSel = NpAlu;
            dec.imm       = iImm;
         end
         OpBranch: begin
            dec.aluInSel1 = 1'b1;                   // target pc + imm
            dec.aluInSel2 = 1'b1;
            dec.nextPcSel = NpPredicate;
            dec.imm       = bImm;
         end
         OpAluImm: begin
            dec.wbEn        = 1'b1;
            dec.aluSel      = 1'b1;
            dec.aluInSel2   = 1'b1;
            // funct7 bit only matters for srai
            dec.aluQual     = aluOpIsShift ? instr.rType.funct7[5] : 1'b0;
            dec.needWaitAlu = aluOpIsShift;
            dec.imm         = iImm;
         end
         OpAluReg: begin
            dec.wbEn        = 1'b1;
            dec.aluSel      = 1'b1;
            dec.aluQual     = instr.rType.funct7[5];   // sub, sra
            dec.needWaitAlu = aluOpIsShift;
         end
         OpLoad: begin
            dec.wbEn      = 1'b1;
            dec.wbSel     = WbRam;
            dec.aluInSel2 = 1'b1;                   // effective address
            dec.isLoad    = 1'b1;
            dec.imm       = iImm;
         end
         OpStore: begin
            dec.aluInSel2 = 1'b1;
            dec.isStore   = 1'b1;
            dec.imm       = sImm;
         end
         default: begin
            dec.wbEn      = 1'b0;
            dec.nextPcSel = NpPlus4;
         end
      endcase
   end

endmodule

/* rtl/rvMiniCore.sv */
//******************************
// mini RV32I core top: fetch, queue, execute
//******************************
`timescale 1ns/1ns

module rvMiniCore import rvMiniPkg::*; #(
   parameter int          QueueDepth = QueueDepthDef,
   parameter logic [31:0] ResetPc    = ResetPcDef
) (
   input  logic    clk,
   input  logic    rst,
   output axiAr_t  axiAr,
   input  logic    arready,
   input  axiR_t   axiR,
   output logic    rready,
   output retire_t retire
);

   logic        pushValid;
   queueEntry_t pushEntry;
   logic        notFull;
   logic        headValid;
   queueEntry_t head;
   logic        pop;
   redirect_t   redirect;

   fetchUnit #(.ResetPc(ResetPc)) fetch (
      .clk(clk), .rst(rst),
      .axiAr(axiAr), .arready(arready), .axiR(axiR), .rready(rready),
      .notFull(notFull), .redirect(redirect),
      .pushValid(pushValid), .pushEntry(pushEntry)
   );

   instrQueue #(.QueueDepth(QueueDepth)) queue (
      .clk(clk), .rst(rst),
      .pushValid(pushValid), .pushEntry(pushEntry), .notFull(notFull),
      .headValid(headValid), .head(head), .pop(pop),
      .flush(redirect.valid)                       // wrong path words dropped
   );

   execUnit exec (
      .clk(clk), .rst(rst),
      .headValid(headValid), .head(head), .pop(pop),
      .redirect(redirect), .retire(retire)
   );

endmodule

/* rtl/rvMiniPkg.sv */
//******************************
// shared types for the mini RV32I core: parameter defaults,
// opcodes, instruction union, decode, queue, redirect, retire and AXI structs
//******************************
package rvMiniPkg;

   localparam int          QueueDepthDef = 4;        // instruction queue entries
   localparam logic [31:0] ResetPcDef    = 32'h0;    // first fetch address

   // opcode classes, bits 6..2 of the instruction
   localparam logic [4:0] OpLui    = 5'b01101;
   localparam logic [4:0] OpAuipc  = 5'b00101;
   localparam logic [4:0] OpJal    = 5'b11011;
   localparam logic [4:0] OpJalr   = 5'b11001;
   localparam logic [4:0] OpBranch = 5'b11000;
   localparam logic [4:0] OpAluImm = 5'b00100;
   localparam logic [4:0] OpAluReg = 5'b01100;
   localparam logic [4:0] OpLoad   = 5'b00000;
   localparam logic [4:0] OpStore  = 5'b01000;

   typedef enum logic [3:0] {
      WbAlu     = 4'b0001,   // alu result
      WbPcPlus4 = 4'b0010,   // link address
      WbRam     = 4'b0100,   // load data, not written back here
      WbCounter = 4'b1000    // counters, not present
   } wbSel_e;

   typedef enum logic [2:0] {
      NpPlus4     = 3'b001,  // sequential
      NpAlu       = 3'b010,  // jump target from adder
      NpPredicate = 3'b100   // branch, adder if taken
   } nextPcSel_e;

   // one instruction word, seen in each base format
   typedef union packed {
      struct packed {
         logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
         logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
      } rType;
      struct packed {
         logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
         logic [4:0] rd;   logic [6:0] opcode;
      } iType;
      struct packed {
         logic [6:0] immHi; logic [4:0] rs2;   logic [4:0] rs1;
         logic [2:0] funct3; logic [4:0] immLo; logic [6:0] opcode;
      } sType;
      struct packed {
         logic imm12; logic [5:0] imm10to5; logic [4:0] rs2; logic [4:0] rs1;
         logic [2:0] funct3; logic [3:0] imm4to1; logic imm11; logic [6:0] opcode;
      } bType;
      struct packed {
         logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
      } uType;
      struct packed {
         logic imm20; logic [9:0] imm10to1; logic imm11; logic [7:0] imm19to12;
         logic [4:0] rd; logic [6:0] opcode;
      } jType;
   } instrWord_u;

   typedef struct packed {
      logic [4:0]  wbRegId;
      logic        wbEn;
      wbSel_e      wbSel;
      logic [4:0]  inRegId1;
      logic [4:0]  inRegId2;
      logic        aluSel;       // 0 forces add
      logic        aluInSel1;    // 0 reg, 1 pc
      logic        aluInSel2;    // 0 reg, 1 imm
      logic [2:0]  aluOp;
      logic        aluQual;      // sub / arithmetic right shift
      logic        isLoad;
      logic        isStore;
      logic        needWaitAlu;  // serial shift in progress
      nextPcSel_e  nextPcSel;
      logic [31:0] imm;
   } decode_t;

   typedef struct packed {
      logic [31:0] pc;
      instrWord_u  instr;
   } queueEntry_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] target;
   } redirect_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [4:0]  rd;
      logic        wrEn;
      logic [31:0] value;
      logic [31:0] memAddr;
      logic        isMem;
   } retire_t;

   typedef struct packed {
      logic        arvalid;
      logic [31:0] araddr;
      logic [2:0]  arprot;
   } axiAr_t;

   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axiR_t;

endpackage

/* rvMini.f */
rtl/rvMiniPkg.sv
rtl/nrvDecoder.sv
rtl/fetchUnit.sv
rtl/instrQueue.sv
rtl/execUnit.sv
rtl/rvMiniCore.sv
dv/rvMiniTb.sv
